// File: hw/cpu11_consts.svh
`ifndef CPU11_CONSTS_SVH
`define CPU11_CONSTS_SVH

// datapath and bus width
`define CPU11_WORD      16
`define CPU11_NREGS     8

// register numbers
`define CPU11_PC        7
`define CPU11_SP        6

`define CPU11_BOOT_PC   16'o001000  // first fetch after reset

`endif

// File: hw/cpu11_pkg.sv
package cpu11_pkg;

    // ==============================
    // enums

    typedef enum logic [3:0] {
        S_BOOT, S_FETCH, S_DECODE,
        S_SRC_ADDR, S_SRC_READ,
        S_DST_ADDR, S_DST_READ,
        S_EXEC, S_WRITEBACK, S_BRANCH, S_HALTED
    } state_t;

    typedef enum logic [3:0] {
        ALU_PASS_A, ALU_ADD, ALU_SUB, ALU_AND_NOT, ALU_OR, ALU_AND, ALU_COM,
        ALU_NEG, ALU_INC, ALU_DEC, ALU_INC2, ALU_DEC2, ALU_CLR
    } alu_op_t;

    typedef enum logic [2:0] {
        COND_ALWAYS, COND_NE, COND_EQ, COND_PL, COND_MI
    } cond_t;

    typedef enum logic [1:0] {
        IC_DOUBLE, IC_SINGLE, IC_BRANCH, IC_HALT
    } instr_class_t;

    typedef enum logic [1:0] {A_REG, A_SRC, A_DST, A_PC} a_sel_t;
    typedef enum logic [1:0] {B_SRC, B_DST, B_ZERO, B_BR_OFFSET} b_sel_t;
    typedef enum logic {ADDR_PC, ADDR_ADR} addr_sel_t;

    // ==============================
    // structs

    typedef struct packed {
        instr_class_t      cls;
        alu_op_t           alu_op;
        cond_t             cond;
        logic [2:0]        src_mode;
        logic [2:0]        dst_mode;
        logic [2:0]        src_reg;
        logic [2:0]        dst_reg;
        logic              writeback;   // result goes back to dst
        logic              set_flags;
        logic signed [7:0] br_offset;   // in words
    } decoded_t;

    typedef struct packed {
        alu_op_t   alu_op;
        a_sel_t    a_sel;
        b_sel_t    b_sel;
        logic      reg_sel;       // 0 source field, 1 destination field
        logic      reg_we;
        logic      pc_we;
        logic      src_ld;
        logic      dst_ld;
        logic      adr_ld;
        logic      adr_from_bus;
        logic      from_bus;      // src/dst take data_i instead of alu
        logic      set_flags;
        logic      ir_ld;
        addr_sel_t addr_sel;
    } dp_cmd_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flags_t;

endpackage

// File: hw/cpu11_decode.sv
`timescale 1ns/1ps
`include "cpu11_consts.svh"

module cpu11_decode import cpu11_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  dp_cmd_t                cmd_i,
    input  logic [`CPU11_WORD-1:0] data_i,
    output decoded_t               decoded_o
);

    logic [`CPU11_WORD-1:0] ir_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ir_q <= '0;     // decodes as halt
        end else if (cmd_i.ir_ld) begin
            ir_q <= data_i;
        end
    end

    // only modes 0, 1, 2 and 4
    function automatic logic mode_ok(input logic [2:0] m);
        return m == 3'd0 || m == 3'd1 || m == 3'd2 || m == 3'd4;
    endfunction

    always_comb begin
        decoded_o           = '0;
        decoded_o.cls       = IC_HALT;
        decoded_o.alu_op    = ALU_PASS_A;
        decoded_o.cond      = COND_ALWAYS;
        decoded_o.src_mode  = ir_q[11:9];
        decoded_o.src_reg   = ir_q[8:6];
        decoded_o.dst_mode  = ir_q[5:3];
        decoded_o.dst_reg   = ir_q[2:0];
        decoded_o.br_offset = ir_q[7:0];

        if (ir_q[15:12] inside {4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'he}) begin
            if (mode_ok(ir_q[11:9]) && mode_ok(ir_q[5:3])) begin
                decoded_o.cls       = IC_DOUBLE;
                decoded_o.writeback = 1'b1;
                decoded_o.set_flags = 1'b1;
                case (ir_q[14:12])
                    3'd1: decoded_o.alu_op = ALU_PASS_A;    // mov
                    3'd2: begin                             // cmp
                        decoded_o.alu_op    = ALU_SUB;
                        decoded_o.writeback = 1'b0;
                    end
                    3'd3: begin                             // bit
                        decoded_o.alu_op    = ALU_AND;
                        decoded_o.writeback = 1'b0;
                    end
                    3'd4: decoded_o.alu_op = ALU_AND_NOT;   // bic
                    3'd5: decoded_o.alu_op = ALU_OR;        // bis
                    default: decoded_o.alu_op = ir_q[15] ? ALU_SUB : ALU_ADD;
                endcase
            end
        end else if (ir_q[15:9] == 7'b0000101) begin
            if (mode_ok(ir_q[5:3]) && !(ir_q[8:6] inside {3'd5, 3'd6})) begin
                decoded_o.cls       = IC_SINGLE;
                decoded_o.writeback = 1'b1;
                decoded_o.set_flags = 1'b1;
                case (ir_q[8:6])
                    3'd0: decoded_o.alu_op = ALU_CLR;
                    3'd1: decoded_o.alu_op = ALU_COM;
                    3'd2: decoded_o.alu_op = ALU_INC;
                    3'd3: decoded_o.alu_op = ALU_DEC;
                    3'd4: decoded_o.alu_op = ALU_NEG;
                    default: begin                          // tst as dst - 0
                        decoded_o.alu_op    = ALU_SUB;
                        decoded_o.writeback = 1'b0;
                    end
                endcase
            end
        end else if (ir_q[15:8] inside {8'h01, 8'h02, 8'h03, 8'h80, 8'h81}) begin
            decoded_o.cls = IC_BRANCH;
            case (ir_q[15:8])
                8'h02: decoded_o.cond = COND_NE;
                8'h03: decoded_o.cond = COND_EQ;
                8'h80: decoded_o.cond = COND_PL;
                8'h81: decoded_o.cond = COND_MI;
                default: decoded_o.cond = COND_ALWAYS;
            endcase
        end
    end

endmodule

// File: hw/cpu11_regs.sv
`timescale 1ns/1ps
`include "cpu11_consts.svh"

module cpu11_regs import cpu11_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  dp_cmd_t                cmd_i,
    input  decoded_t               decoded_i,
    input  logic [`CPU11_WORD-1:0] alu_result_i,
    input  logic [`CPU11_WORD-1:0] data_i,
    output logic [`CPU11_WORD-1:0] reg_o,
    output logic [`CPU11_WORD-1:0] src_o,
    output logic [`CPU11_WORD-1:0] dst_o,
    output logic [`CPU11_WORD-1:0] pc_o,
    output logic [`CPU11_WORD-1:0] addr_o,
    output logic [`CPU11_WORD-1:0] data_o
);

    logic [`CPU11_WORD-1:0] r_q [`CPU11_NREGS];
    logic [`CPU11_WORD-1:0] src_q;
    logic [`CPU11_WORD-1:0] dst_q;
    logic [`CPU11_WORD-1:0] adr_q;
    logic [2:0]             sel;
    logic [`CPU11_WORD-1:0] opnd_d;

    assign sel    = cmd_i.reg_sel ? decoded_i.dst_reg : decoded_i.src_reg;
    assign opnd_d = cmd_i.from_bus ? data_i : alu_result_i;

    // ==============================
    // register file and operand latches

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `CPU11_NREGS; i++) begin
                r_q[i] <= '0;
            end
            r_q[`CPU11_PC] <= `CPU11_BOOT_PC;
            src_q <= '0;
            dst_q <= '0;
            adr_q <= '0;
        end else begin
            if (cmd_i.reg_we) r_q[sel] <= alu_result_i;
            if (cmd_i.pc_we) r_q[`CPU11_PC] <= alu_result_i;
            if (cmd_i.src_ld) src_q <= opnd_d;
            if (cmd_i.dst_ld) dst_q <= opnd_d;
            if (cmd_i.adr_ld) adr_q <= alu_result_i;   // register value, pre or post step
        end
    end

    assign reg_o = r_q[sel];
    assign src_o = src_q;
    assign dst_o = dst_q;
    assign pc_o  = r_q[`CPU11_PC];

    // bus side
    assign addr_o = (cmd_i.addr_sel == ADDR_ADR) ? adr_q : r_q[`CPU11_PC];
    assign data_o = dst_q;     // writeback data

endmodule

// File: hw/cpu11_alu.sv
`timescale 1ns/1ps
`include "cpu11_consts.svh"

module cpu11_alu import cpu11_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  dp_cmd_t                cmd_i,
    input  decoded_t               decoded_i,
    input  logic [`CPU11_WORD-1:0] reg_i,
    input  logic [`CPU11_WORD-1:0] src_i,
    input  logic [`CPU11_WORD-1:0] dst_i,
    input  logic [`CPU11_WORD-1:0] pc_i,
    output logic [`CPU11_WORD-1:0] result_o,
    output logic                   branch_taken_o
);

    localparam int MSB = `CPU11_WORD - 1;

    logic [MSB:0] a;
    logic [MSB:0] b;
    logic [MSB:0] r;
    logic [MSB+1:0] wide;   // carry or borrow on top
    logic [MSB:0] br_ofs;
    flags_t       flags_q;
    flags_t       flags_d;

    assign br_ofs = {{(`CPU11_WORD-9){decoded_i.br_offset[7]}}, decoded_i.br_offset, 1'b0};

    always_comb begin
        case (cmd_i.a_sel)
            A_SRC:   a = src_i;
            A_DST:   a = dst_i;
            A_PC:    a = pc_i;
            default: a = reg_i;
        endcase
        case (cmd_i.b_sel)
            B_SRC:       b = src_i;
            B_DST:       b = dst_i;
            B_BR_OFFSET: b = br_ofs;
            default:     b = '0;
        endcase
    end

    // ==============================
    // result and word flags

    always_comb begin
        wide      = '0;
        r         = a;
        flags_d.v = 1'b0;
        flags_d.c = flags_q.c;    // kept unless the op says otherwise
        case (cmd_i.alu_op)
            ALU_ADD: begin
                wide      = {1'b0, a} + {1'b0, b};
                r         = wide[MSB:0];
                flags_d.v = (a[MSB] == b[MSB]) && (r[MSB] != a[MSB]);
                flags_d.c = wide[MSB+1];
            end
            ALU_SUB: begin
                wide      = {1'b0, a} - {1'b0, b};
                r         = wide[MSB:0];
                flags_d.v = (a[MSB] != b[MSB]) && (r[MSB] != a[MSB]);
                flags_d.c = wide[MSB+1];
            end
            ALU_AND_NOT: r = a & ~b;
            ALU_OR:      r = a | b;
            ALU_AND:     r = a & b;
            ALU_COM: begin
                r         = ~a;
                flags_d.c = 1'b1;
            end
            ALU_NEG: begin
                r         = '0 - a;
                flags_d.v = (r == {1'b1, {MSB{1'b0}}});
                flags_d.c = (r != '0);
            end
            ALU_INC: begin
                r         = a + 1'b1;
                flags_d.v = (r == {1'b1, {MSB{1'b0}}});
            end
            ALU_DEC: begin
                r         = a - 1'b1;
                flags_d.v = (r == {1'b0, {MSB{1'b1}}});
            end
            ALU_INC2: r = a + 2'd2;
            ALU_DEC2: r = a - 2'd2;
            ALU_CLR: begin
                r         = '0;
                flags_d.c = 1'b0;
            end
            default: r = a;
        endcase
        flags_d.n = r[MSB];
        flags_d.z = (r == '0);
    end

    assign result_o = r;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            flags_q <= '0;
        end else if (cmd_i.set_flags) begin
            flags_q <= flags_d;
        end
    end

    always_comb begin
        case (decoded_i.cond)
            COND_NE: branch_taken_o = !flags_q.z;
            COND_EQ: branch_taken_o = flags_q.z;
            COND_PL: branch_taken_o = !flags_q.n;
            COND_MI: branch_taken_o = flags_q.n;
            default: branch_taken_o = 1'b1;   // br
        endcase
    end

endmodule

// File: hw/cpu11_control.sv
`timescale 1ns/1ps

module cpu11_control import cpu11_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  decoded_t decoded_i,
    input  logic     branch_taken_i,
    input  logic     ready_i,
    output dp_cmd_t  cmd_o,
    output logic     dati_o,
    output logic     dato_o,
    output logic     halted_o
);

    localparam logic OP_SRC = 1'b0;
    localparam logic OP_DST = 1'b1;

    state_t     state_q;
    state_t     state_d;
    logic       phase_q;    // which operand is being fetched
    logic       phase_d;
    logic [2:0] mode;
    state_t     read_st;
    state_t     done_st;

    assign mode    = (phase_q == OP_DST) ? decoded_i.dst_mode : decoded_i.src_mode;
    assign read_st = (phase_q == OP_DST) ? S_DST_READ : S_SRC_READ;
    assign done_st = (phase_q == OP_DST) ? S_EXEC : S_DST_ADDR;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= S_BOOT;
            phase_q <= OP_SRC;
        end else begin
            state_q <= state_d;
            phase_q <= phase_d;
        end
    end

    assign halted_o = (state_q == S_HALTED);

    // ==============================
    // command and strobes per state

    always_comb begin
        cmd_o          = '0;
        cmd_o.alu_op   = ALU_PASS_A;
        cmd_o.a_sel    = A_REG;
        cmd_o.b_sel    = B_ZERO;
        cmd_o.reg_sel  = phase_q;
        cmd_o.addr_sel = ADDR_PC;
        dati_o         = 1'b0;
        dato_o         = 1'b0;
        state_d        = state_q;
        phase_d        = phase_q;

        case (state_q)
            S_BOOT: state_d = S_FETCH;     // pc already at boot address
            S_FETCH: begin
                dati_o = 1'b1;
                if (ready_i) begin
                    cmd_o.ir_ld  = 1'b1;
                    cmd_o.a_sel  = A_PC;
                    cmd_o.alu_op = ALU_INC2;
                    cmd_o.pc_we  = 1'b1;
                    state_d      = S_DECODE;
                end
            end
            S_DECODE: begin
                case (decoded_i.cls)
                    IC_DOUBLE: begin
                        phase_d = OP_SRC;
                        state_d = S_SRC_ADDR;
                    end
                    IC_SINGLE: begin
                        phase_d = OP_DST;
                        state_d = S_DST_ADDR;
                    end
                    IC_BRANCH: state_d = S_BRANCH;
                    default:   state_d = S_HALTED;
                endcase
            end
            S_SRC_ADDR, S_DST_ADDR: begin
                if (mode == 3'd0) begin
                    cmd_o.src_ld = (phase_q == OP_SRC);
                    cmd_o.dst_ld = (phase_q == OP_DST);
                    phase_d      = OP_DST;
                    state_d      = done_st;
                end else begin
                    cmd_o.adr_ld = 1'b1;
                    if (mode == 3'd4) begin   // predecrement
                        cmd_o.alu_op = ALU_DEC2;
                        cmd_o.reg_we = 1'b1;
                    end
                    state_d = read_st;
                end
            end
            S_SRC_READ, S_DST_READ: begin
                dati_o         = 1'b1;
                cmd_o.addr_sel = ADDR_ADR;
                if (ready_i) begin
                    cmd_o.from_bus = 1'b1;
                    cmd_o.src_ld   = (phase_q == OP_SRC);
                    cmd_o.dst_ld   = (phase_q == OP_DST);
                    if (mode == 3'd2) begin   // postincrement
                        cmd_o.alu_op = ALU_INC2;
                        cmd_o.reg_we = 1'b1;
                    end
                    phase_d = OP_DST;
                    state_d = done_st;
                end
            end
            S_EXEC: begin
                cmd_o.alu_op    = decoded_i.alu_op;
                cmd_o.set_flags = decoded_i.set_flags;
                cmd_o.dst_ld    = 1'b1;
                if (decoded_i.cls == IC_SINGLE) begin
                    cmd_o.a_sel = A_DST;
                end else if (decoded_i.alu_op == ALU_AND_NOT ||
                             (decoded_i.alu_op == ALU_SUB && decoded_i.writeback)) begin
                    cmd_o.a_sel = A_DST;  // dst op src
                    cmd_o.b_sel = B_SRC;
                end else begin
                    cmd_o.a_sel = A_SRC;
                    cmd_o.b_sel = B_DST;
                end
                state_d = decoded_i.writeback ? S_WRITEBACK : S_FETCH;
            end
            S_WRITEBACK: begin
                if (decoded_i.dst_mode == 3'd0) begin
                    cmd_o.a_sel   = A_DST;
                    cmd_o.reg_sel = OP_DST;
                    cmd_o.reg_we  = 1'b1;
                    state_d       = S_FETCH;
                end else begin
                    dato_o         = 1'b1;
                    cmd_o.addr_sel = ADDR_ADR;
                    if (ready_i) state_d = S_FETCH;
                end
            end
            S_BRANCH: begin
                if (branch_taken_i) begin
                    cmd_o.a_sel  = A_PC;
                    cmd_o.b_sel  = B_BR_OFFSET;
                    cmd_o.alu_op = ALU_ADD;
                    cmd_o.pc_we  = 1'b1;
                end
                state_d = S_FETCH;
            end
            default: state_d = S_HALTED;   // halted until reset
        endcase
    end

endmodule

// File: hw/cpu11_top.sv
`timescale 1ns/1ps
`include "cpu11_consts.svh"

module cpu11_top import cpu11_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [`CPU11_WORD-1:0] data_i,
    input  logic                   ready_i,
    output logic [`CPU11_WORD-1:0] addr_o,
    output logic [`CPU11_WORD-1:0] data_o,
    output logic                   dati_o,
    output logic                   dato_o,
    output logic                   halted_o
);

    dp_cmd_t                cmd;
    decoded_t               dec;
    logic                   branch_taken;
    logic [`CPU11_WORD-1:0] alu_result;
    logic [`CPU11_WORD-1:0] reg_val;
    logic [`CPU11_WORD-1:0] src_val;
    logic [`CPU11_WORD-1:0] dst_val;
    logic [`CPU11_WORD-1:0] pc_val;

    cpu11_control u_control (
        .clk            (clk),
        .reset_n        (reset_n),
        .decoded_i      (dec),
        .branch_taken_i (branch_taken),
        .ready_i        (ready_i),
        .cmd_o          (cmd),
        .dati_o         (dati_o),
        .dato_o         (dato_o),
        .halted_o       (halted_o)
    );

    cpu11_decode u_decode (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_i     (cmd),
        .data_i    (data_i),
        .decoded_o (dec)
    );

    cpu11_regs u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_i        (cmd),
        .decoded_i    (dec),
        .alu_result_i (alu_result),
        .data_i       (data_i),
        .reg_o        (reg_val),
        .src_o        (src_val),
        .dst_o        (dst_val),
        .pc_o         (pc_val),
        .addr_o       (addr_o),
        .data_o       (data_o)
    );

    cpu11_alu u_alu (
        .clk            (clk),
        .reset_n        (reset_n),
        .cmd_i          (cmd),
        .decoded_i      (dec),
        .reg_i          (reg_val),
        .src_i          (src_val),
        .dst_i          (dst_val),
        .pc_i           (pc_val),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

endmodule

// File: tb/tb_cpu11.sv
`timescale 1ns/1ps
`include "cpu11_consts.svh"

module tb_cpu11;

    localparam int CLK_PERIOD   = 100;
    localparam int IN_DELAY     = 10;     // input drive after the rising edge
    localparam int MEM_WORDS    = 32768;
    localparam int HALT_TIMEOUT = 5000;
    localparam int IDLE_LIMIT   = 50;

    logic                   clk;
    logic                   reset_n;
    logic [`CPU11_WORD-1:0] data_i;
    logic                   ready_i;
    logic [`CPU11_WORD-1:0] addr_o;
    logic [`CPU11_WORD-1:0] data_o;
    logic                   dati_o;
    logic                   dato_o;
    logic                   halted_o;

    logic [`CPU11_WORD-1:0] mem [MEM_WORDS];
    logic [`CPU11_WORD-1:0] exp_addr [$];
    logic [`CPU11_WORD-1:0] exp_data [$];
    logic [31:0]            lcg_state;

    cpu11_top i_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .data_i   (data_i),
        .ready_i  (ready_i),
        .addr_o   (addr_o),
        .data_o   (data_o),
        .dati_o   (dati_o),
        .dato_o   (dato_o),
        .halted_o (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ==============================
    // helpers

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_idle_bus(input string when);
        assert (!dati_o && !dato_o && !halted_o)
            else report_fail($sformatf("strobe or halted_o high %s", when));
    endtask

    // address, data and strobe must not move until ready
    task automatic check_hold(input logic [15:0] a, input logic [15:0] d, input logic wr);
        assert (addr_o == a && data_o == d && dato_o == wr && dati_o == !wr)
            else report_fail($sformatf("bus moved during transfer: addr 0x%h data 0x%h",
                                       addr_o, data_o));
    endtask

    task automatic check_write(input logic [15:0] a, input logic [15:0] d);
        assert (exp_addr.size() != 0)
            else report_fail($sformatf("unexpected write of 0x%h to 0x%h", d, a));
        assert (a == exp_addr[0] && d == exp_data[0])
            else report_fail($sformatf("write 0x%h to 0x%h, expected 0x%h to 0x%h",
                                       d, a, exp_data[0], exp_addr[0]));
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        mem[a[15:1]] = d;
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 n;
        logic [7:0]         kind;
        logic [15:0]        a;
        logic [15:0]        v;
        logic [8*120-1:0]   rest;
        bit                 done;
        bit                 end_seen;
        fd = $fopen("tb/cpu11_vectors.txt", "r");
        assert (fd != 0) else report_fail("cannot open tb/cpu11_vectors.txt");
        done     = 1'b0;
        end_seen = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                done = 1'b1;
            end else if (kind == "M" || kind == "W") begin
                n = $fscanf(fd, "%h %h", a, v);
                assert (n == 2) else report_fail("malformed record in vector file");
                if (kind == "M") begin
                    mem[a[15:1]] = v;
                end else begin
                    exp_addr.push_back(a);
                    exp_data.push_back(v);
                end
            end else if (kind == "H") begin
                end_seen = 1'b1;
                done     = 1'b1;
            end else begin
                n = $fgets(rest, fd);   // comment up to end of line
            end
        end
        $fclose(fd);
        assert (end_seen) else report_fail("vector file has no H record");
    endtask

    // ==============================
    // memory model with random wait states

    initial begin : memory_model
        logic [15:0] a;
        logic [15:0] d;
        logic        wr;
        int          waits;
        int          idle;
        bit          first;
        ready_i   = 1'b0;
        data_i    = '0;
        lcg_state = 32'hf7ec;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 16'(i * 2) ^ 16'h6b3d;
        end
        load_vectors();
        first = 1'b1;
        idle  = 0;
        forever begin
            @(negedge clk);
            if (!dati_o && !dato_o) begin
                idle++;
                assert (!reset_n || halted_o || idle < IDLE_LIMIT)
                    else report_fail("no bus cycle for too long before halt");
            end else begin
                idle = 0;
                assert (!(dati_o && dato_o)) else report_fail("read and write strobes both high");
                a  = addr_o;
                d  = data_o;
                wr = dato_o;
                if (first) begin
                    assert (!wr && a == `CPU11_BOOT_PC)
                        else report_fail($sformatf("first bus cycle at 0x%h", a));
                    first = 1'b0;
                end
                lcg_state = lcg_step(lcg_state);
                waits     = int'(lcg_state[31:30]);
                repeat (waits) begin
                    @(negedge clk);
                    check_hold(a, d, wr);
                end
                @(posedge clk);
                #IN_DELAY;
                ready_i = 1'b1;
                if (!wr) data_i = mem[a[15:1]];
                @(negedge clk);
                check_hold(a, d, wr);
                if (wr) check_write(a, d);
                @(posedge clk);
                #IN_DELAY;
                ready_i = 1'b0;
                data_i  = '0;
            end
        end
    end

    // ==============================
    // reset, run to halt, final checks

    initial begin : main
        int cycles;
        reset_n = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_idle_bus("during reset");
        end
        @(posedge clk);
        #IN_DELAY;
        reset_n = 1'b1;
        @(negedge clk);
        check_idle_bus("right after reset");

        cycles = 0;
        while (!halted_o && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted_o) else report_fail("timeout waiting for halted_o");
        assert (exp_addr.size() == 0)
            else report_fail($sformatf("%0d expected writes never seen", exp_addr.size()));
        repeat (20) begin
            @(negedge clk);
            assert (halted_o && !dati_o && !dato_o)
                else report_fail("bus activity or halted_o low after halt");
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: tb/cpu11_vectors.txt
// kind, address, value in hex; M loads a memory word, W is the next expected write
// H ends the list; text after // is ignored
M 0200 15c3  // mov #500, r3
M 0202 0500
M 0204 14c2  // mov (r3)+, r2
M 0206 6093  // add r2, (r3)+
M 0208 e093  // sub r2, (r3)+
M 020a 4093  // bic r2, (r3)+
M 020c 5093  // bis r2, (r3)+
M 020e 1093  // mov r2, (r3)+
M 0210 0a13  // clr (r3)+
M 0212 0a53  // com (r3)+
M 0214 0a93  // inc (r3)+
M 0216 0ad3  // dec (r3)+
M 0218 0b13  // neg (r3)+
M 021a 0a63  // com -(r3)
M 021c 608b  // add r2, (r3)
M 021e 2082  // cmp r2, r2
M 0220 0201  // bne not taken
M 0222 1093  // mov r2, (r3)+
M 0224 0301  // beq not taken
M 0226 0a13  // clr (r3)+
M 0228 0301  // beq taken
M 022a 0000
M 022c 0bc2  // tst r2
M 022e 8101  // bmi not taken
M 0230 8001  // bpl taken
M 0232 0000
M 0234 0b02  // neg r2
M 0236 8001  // bpl not taken
M 0238 1093  // mov r2, (r3)+
M 023a 8101  // bmi taken
M 023c 0000
M 023e 3082  // bit r2, r2
M 0240 0201  // bne taken
M 0242 0000
M 0244 0101  // br taken
M 0246 0000
M 0248 0a13  // clr (r3)+
M 024a 0000  // halt
// operand data
M 0500 0f0f
M 0502 7100
M 0504 0100
M 0506 fff0
M 0508 1020
M 050e 1234
M 0510 7fff
M 0512 0000
M 0514 0005
// expected writes in order
W 0502 800f  // add
W 0504 f1f1  // sub
W 0506 f0f0  // bic
W 0508 1f2f  // bis
W 050a 0f0f  // mov
W 050c 0000  // clr
W 050e edcb  // com
W 0510 8000  // inc
W 0512 ffff  // dec
W 0514 fffb  // neg
W 0514 0004  // com -(r3)
W 0514 0f13  // add r2, (r3)
W 0514 0f0f  // after bne
W 0516 0000  // after beq
W 0518 f0f1  // after bpl
W 051a 0000  // after br
H

// File: tb.f
+incdir+hw
hw/cpu11_pkg.sv
hw/cpu11_decode.sv
hw/cpu11_regs.sv
hw/cpu11_alu.sv
hw/cpu11_control.sv
hw/cpu11_top.sv
tb/tb_cpu11.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f tb.f --top-module tb_cpu11 -o tb_cpu11
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu11
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0
